// ==== list.f ====
rtl/uart_bus_pkg.sv
rtl/uart_line_pkg.sv
rtl/axils_local_bridge.sv
rtl/uart_regs.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/axis_uart_top.sv
testbench/uart_assertions.sv
testbench/uart_checker.sv
testbench/tb_axis_uart.sv

// ==== Bender.yml ====
package:
  name: axis_uart

sources:
  - files:
      - rtl/uart_bus_pkg.sv
      - rtl/uart_line_pkg.sv
      - rtl/axils_local_bridge.sv
      - rtl/uart_regs.sv
      - rtl/uart_tx.sv
      - rtl/uart_rx.sv
      - rtl/axis_uart_top.sv
  - target: test
    files:
      - testbench/uart_assertions.sv
      - testbench/uart_checker.sv
      - testbench/tb_axis_uart.sv

// ==== testbench/tb_axis_uart.sv ====
`timescale 1ns/1ps

module tb_axis_uart
   import uart_bus_pkg::*;
   import uart_line_pkg::*;
();

   logic      ACLK;
   logic      ARESETN;
   bus_addr_t s_axi_awaddr;
   logic      s_axi_awvalid;
   logic      s_axi_awready;
   bus_data_t s_axi_wdata;
   bus_strb_t s_axi_wstrb;
   logic      s_axi_wvalid;
   logic      s_axi_wready;
   logic      s_axi_bvalid;
   logic      s_axi_bready;
   axi_resp_t s_axi_bresp;
   bus_addr_t s_axi_araddr;
   logic      s_axi_arvalid;
   logic      s_axi_arready;
   bus_data_t s_axi_rdata;
   axi_resp_t s_axi_rresp;
   logic      s_axi_rvalid;
   logic      s_axi_rready;
   logic      uart_txd;
   logic      uart_rxd;

   int          check_errors;
   logic        line_quiet;
   logic [31:0] lfsr = 32'h5e07_3a91;
   int          tests_run = 0;
   int          tests_failed = 0;
   int          errors_before = 0;

   // the serial line is looped back onto the receiver.
   assign uart_rxd = uart_txd;

   axis_uart_top dut (.*);

   uart_checker u_checker (.*, .errors(check_errors), .quiet(line_quiet));

   initial begin
      ACLK = 1'b0;
      forever #20 ACLK = ~ACLK;
   end

   // six tests of up to twenty frames each, with a margin of two.
   initial begin
      #(6 * 20 * 10 * CLKS_PER_BIT * 40 * 2);
      $display("ERROR: the run hung and the watchdog expired at %0t", $time);
      $display("TESTS FAILED");
      $finish;
   end

   function automatic logic next_bit();
      logic b;
      b = lfsr[0];
      lfsr = (lfsr >> 1) ^ (b ? 32'hD000_0001 : 32'h0);
      return b;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) v = {v[30:0], next_bit()};
      return v;
   endfunction

   function automatic int total_errors();
      return check_errors + dut.u_bridge.u_assertions.fail_count;
   endfunction

   task automatic axi_write(input bus_addr_t addr, input bus_data_t data, input bus_strb_t strb);
      int delay;
      @(negedge ACLK);
      s_axi_awaddr  = addr;
      s_axi_awvalid = 1'b1;
      s_axi_wdata   = data;
      s_axi_wstrb   = strb;
      s_axi_wvalid  = 1'b1;
      while (!s_axi_awready) @(negedge ACLK);
      @(negedge ACLK);
      s_axi_awvalid = 1'b0;
      while (!s_axi_wready) @(negedge ACLK);
      @(negedge ACLK);
      s_axi_wvalid = 1'b0;
      delay = int'(rand_bits(2));
      repeat (delay) @(negedge ACLK);
      s_axi_bready = 1'b1;
      while (!s_axi_bvalid) @(negedge ACLK);
      @(negedge ACLK);
      s_axi_bready = 1'b0;
   endtask

   task automatic axi_read(input bus_addr_t addr, output bus_data_t data);
      int delay;
      @(negedge ACLK);
      s_axi_araddr  = addr;
      s_axi_arvalid = 1'b1;
      while (!s_axi_arready) @(negedge ACLK);
      @(negedge ACLK);
      s_axi_arvalid = 1'b0;
      delay = int'(rand_bits(2));
      repeat (delay) @(negedge ACLK);
      s_axi_rready = 1'b1;
      while (!s_axi_rvalid) @(negedge ACLK);
      data = s_axi_rdata;
      @(negedge ACLK);
      s_axi_rready = 1'b0;
   endtask

   task automatic wait_quiet();
      while (!line_quiet) @(negedge ACLK);
   endtask

   task automatic poll_rx_valid();
      bus_data_t    word;
      uart_status_t status;
      do begin
         axi_read(bus_addr_t'(REG_STATUS), word);
         status = uart_status_t'(word[3:0]);
      end while (!status.rx_valid);
   endtask

   task automatic end_test(input string name);
      int new_errors;
      new_errors = total_errors() - errors_before;
      tests_run++;
      if (new_errors != 0) tests_failed++;
      $display("test %0d %s: %s, %0d errors", tests_run, name,
         (new_errors == 0) ? "ok" : "bad", new_errors);
      errors_before = total_errors();
   endtask

   initial begin
      bus_data_t word;
      int        writes;
      ARESETN       = 1'b0;
      s_axi_awaddr  = '0;
      s_axi_awvalid = 1'b0;
      s_axi_wdata   = '0;
      s_axi_wstrb   = '0;
      s_axi_wvalid  = 1'b0;
      s_axi_bready  = 1'b0;
      s_axi_araddr  = '0;
      s_axi_arvalid = 1'b0;
      s_axi_rready  = 1'b0;
      repeat (2) @(negedge ACLK);
      ARESETN = 1'b1;

      for (int n = 0; n < 8; n++) begin
         axi_write(bus_addr_t'(REG_TXDATA), rand_bits(32), bus_strb_t'(rand_bits(4)) | 4'h1);
      end
      wait_quiet();
      end_test("transmit framing");

      for (int n = 0; n < 6; n++) begin
         axi_write(bus_addr_t'(REG_TXDATA), rand_bits(32), 4'hF);
      end
      for (int n = 0; n < 14; n++) begin
         poll_rx_valid();
         axi_read(bus_addr_t'(REG_RXDATA), word);
      end
      wait_quiet();
      axi_read(bus_addr_t'(REG_RXDATA), word);
      end_test("loopback receive");

      for (int n = 0; n < 3; n++) begin
         axi_write(bus_addr_t'(REG_TXDATA), rand_bits(32), bus_strb_t'(rand_bits(4)) & 4'hE);
      end
      axi_write(bus_addr_t'(REG_TXDATA), rand_bits(32), 4'h1);
      wait_quiet();
      poll_rx_valid();
      axi_read(bus_addr_t'(REG_RXDATA), word);
      end_test("byte strobe");

      // eighteen bytes overflow the sixteen entry receive FIFO.
      axi_read(bus_addr_t'(REG_STATUS), word);
      for (int n = 0; n < 18; n++) begin
         axi_write(bus_addr_t'(REG_TXDATA), rand_bits(32), 4'h1);
      end
      wait_quiet();
      axi_read(bus_addr_t'(REG_STATUS), word);
      axi_read(bus_addr_t'(REG_STATUS), word);
      repeat (17) axi_read(bus_addr_t'(REG_RXDATA), word);
      end_test("status and overrun");

      axi_read(bus_addr_t'(REG_TXDATA), word);
      axi_read(16'h000C, word);
      for (int n = 0; n < 4; n++) begin
         axi_read(bus_addr_t'(rand_bits(16)) | 16'h0010, word);
         axi_write(bus_addr_t'(rand_bits(16)) | 16'h0010, rand_bits(32), 4'hF);
      end
      axi_write(bus_addr_t'(REG_RXDATA), rand_bits(32), 4'hF);
      axi_write(bus_addr_t'(REG_STATUS), rand_bits(32), 4'hF);
      axi_write(16'h000C, rand_bits(32), 4'hF);
      // a wrong push would start its frame well inside two bit periods.
      repeat (2 * CLKS_PER_BIT) @(negedge ACLK);
      wait_quiet();
      end_test("responses and address decode");

      writes = 0;
      for (int n = 0; n < 12; n++) begin
         if (next_bit()) begin
            axi_write(bus_addr_t'(REG_TXDATA), rand_bits(8), 4'h1);
            writes++;
         end else begin
            axi_read(bus_addr_t'(REG_STATUS), word);
         end
      end
      wait_quiet();
      repeat (writes) axi_read(bus_addr_t'(REG_RXDATA), word);
      end_test("random back-pressure");

      $display("tests run %0d, tests failed %0d, errors %0d",
         tests_run, tests_failed, total_errors());
      if (tests_failed == 0 && total_errors() == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== testbench/uart_checker.sv ====
`timescale 1ns/1ps

module uart_checker
   import uart_bus_pkg::*;
   import uart_line_pkg::*;
(
   input  logic      ACLK,
   input  logic      ARESETN,
   input  bus_addr_t s_axi_awaddr,
   input  logic      s_axi_awvalid,
   input  logic      s_axi_awready,
   input  bus_data_t s_axi_wdata,
   input  bus_strb_t s_axi_wstrb,
   input  logic      s_axi_wvalid,
   input  logic      s_axi_wready,
   input  logic      s_axi_bvalid,
   input  logic      s_axi_bready,
   input  axi_resp_t s_axi_bresp,
   input  bus_addr_t s_axi_araddr,
   input  logic      s_axi_arvalid,
   input  logic      s_axi_arready,
   input  bus_data_t s_axi_rdata,
   input  axi_resp_t s_axi_rresp,
   input  logic      s_axi_rvalid,
   input  logic      s_axi_rready,
   input  logic      uart_txd,
   output int        errors,
   output logic      quiet
);

   // bytes still due on the line, and bytes the RXDATA register should return.
   uart_byte_t   line_q[$];
   uart_byte_t   rx_q[$];
   logic         rx_ovr;
   uart_status_t st;
   bus_addr_t    wr_addr;
   bus_data_t    exp_rdata;
   bus_data_t    r_hold;
   logic         rd_check;
   logic         b_seen;
   logic         r_seen;
   logic         b_wait;
   logic         r_wait;
   int           cycle;
   int           w_cycle;
   int           ar_cycle;
   logic         busy;
   int           tick;
   int           idle_cnt;
   uart_byte_t   frame;

   function automatic logic is_reg(input bus_addr_t a, input logic [3:0] off);
      return (a[15:4] == '0) && (a[3:2] == off[3:2]);
   endfunction

   task automatic wrong_value(input string name, input bus_data_t got, input bus_data_t exp);
      $display("FAILED %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      errors++;
   endtask

   task automatic complain(input string what);
      $display("ERROR: %s at %0t", what, $time);
      errors++;
   endtask

   // a decoded frame is compared, then looped back into the receive model.
   task automatic take_frame(input uart_byte_t b);
      uart_byte_t exp_byte;
      exp_byte = b;
      if (line_q.size() == 0) begin
         complain($sformatf("frame 0x%0h on uart_txd with no write pending", b));
      end else begin
         exp_byte = line_q.pop_front();
         if (b != exp_byte) begin
            wrong_value("uart_txd", bus_data_t'(b), bus_data_t'(exp_byte));
         end
      end
      if (rx_q.size() < FIFO_DEPTH) begin
         rx_q.push_back(exp_byte);
      end else begin
         rx_ovr = 1'b1;
      end
   endtask

   always @(posedge ACLK) begin
      if (!ARESETN) begin
         line_q.delete();
         rx_q.delete();
         errors   = 0;
         rx_ovr   = 1'b0;
         rd_check = 1'b0;
         b_seen   = 1'b1;
         r_seen   = 1'b1;
         b_wait   = 1'b0;
         r_wait   = 1'b0;
         cycle    = 0;
         busy     = 1'b0;
         idle_cnt = 0;
         quiet   <= 1'b0;
      end else begin
         cycle++;
         if (cycle == 1 && (!s_axi_awready || !s_axi_arready || s_axi_wready
               || s_axi_bvalid || s_axi_rvalid || !uart_txd)) begin
            complain("outputs not at their reset values");
         end

         // ##############################
         // write channel.
         // ##############################
         if (s_axi_awvalid && s_axi_awready) wr_addr = s_axi_awaddr;
         if (s_axi_wvalid && s_axi_wready) begin
            w_cycle = cycle;
            b_seen  = 1'b0;
            if (is_reg(wr_addr, REG_TXDATA) && s_axi_wstrb[0]) begin
               line_q.push_back(s_axi_wdata[7:0]);
            end
         end
         if (s_axi_bvalid) begin
            if (!b_seen && cycle != w_cycle + 2) begin
               complain("bvalid did not follow the write data by 2 cycles");
            end
            b_seen = 1'b1;
            if (s_axi_bresp != RESP_OKAY) wrong_value("s_axi_bresp", s_axi_bresp, '0);
         end else if (b_wait) begin
            complain("bvalid dropped before bready");
         end
         b_wait = s_axi_bvalid && !s_axi_bready;

         // ##############################
         // read channel.
         // ##############################
         if (s_axi_arvalid && s_axi_arready) begin
            ar_cycle  = cycle;
            r_seen    = 1'b0;
            rd_check  = 1'b1;
            exp_rdata = '0;
            if (is_reg(s_axi_araddr, REG_RXDATA)) begin
               if (rx_q.size() > 0) exp_rdata[7:0] = rx_q.pop_front();
            end else if (is_reg(s_axi_araddr, REG_STATUS)) begin
               // status bits are only predictable once the line has settled.
               rd_check      = quiet;
               st.tx_full    = 1'b0;
               st.tx_empty   = 1'b1;
               st.rx_valid   = (rx_q.size() != 0);
               st.rx_overrun = rx_ovr;
               exp_rdata[3:0] = st;
               rx_ovr = 1'b0;
            end
         end
         if (s_axi_rvalid) begin
            if (!r_seen && cycle != ar_cycle + 2) begin
               complain("rvalid did not follow the read address by 2 cycles");
            end else if (r_seen && s_axi_rdata != r_hold) begin
               wrong_value("s_axi_rdata", s_axi_rdata, r_hold);
            end
            r_seen = 1'b1;
            r_hold = s_axi_rdata;
            if (s_axi_rresp != RESP_OKAY) wrong_value("s_axi_rresp", s_axi_rresp, '0);
            if (s_axi_rready && rd_check && s_axi_rdata != exp_rdata) begin
               wrong_value("s_axi_rdata", s_axi_rdata, exp_rdata);
            end
         end else if (r_wait) begin
            complain("rvalid dropped before rready");
         end
         r_wait = s_axi_rvalid && !s_axi_rready;

         // ##############################
         // serial line, sampled mid-bit.
         // ##############################
         if (busy) begin
            tick++;
            if (tick % CLKS_PER_BIT == CLKS_PER_BIT / 2) begin
               if (tick / CLKS_PER_BIT == 0) begin
                  if (uart_txd) complain("start bit on uart_txd shorter than half a bit");
               end else if (tick / CLKS_PER_BIT <= 8) begin
                  frame[tick / CLKS_PER_BIT - 1] = uart_txd;
               end else begin
                  busy     = 1'b0;
                  idle_cnt = 0;
                  if (!uart_txd) begin
                     complain("stop bit on uart_txd is low");
                  end else begin
                     take_frame(frame);
                  end
               end
            end
         end else if (!uart_txd) begin
            busy = 1'b1;
            tick = 0;
         end else begin
            idle_cnt++;
         end
         quiet <= (line_q.size() == 0) && !busy && (idle_cnt >= 2 * CLKS_PER_BIT);
      end
   end

endmodule

// ==== testbench/uart_assertions.sv ====
`timescale 1ns/1ps

module uart_assertions
   import uart_bus_pkg::*;
(
   input logic          ACLK,
   input logic          ARESETN,
   input logic          s_axi_wready,
   input logic          s_axi_bvalid,
   input logic          s_axi_bready,
   input logic          s_axi_rvalid,
   input logic          s_axi_rready,
   input logic          local_cs,
   input local_req_t    local_req
);

   int fail_count = 0;

   // ##############################
   // response handshakes.
   // ##############################

   a_bvalid_held: assert property (@(posedge ACLK) disable iff (!ARESETN)
      s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
      else begin
         fail_count++;
         $error("bvalid dropped before bready");
      end

   a_rvalid_held: assert property (@(posedge ACLK) disable iff (!ARESETN)
      s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid)
      else begin
         fail_count++;
         $error("rvalid dropped before rready");
      end

   // ##############################
   // local access.
   // ##############################

   a_req_stable: assert property (@(posedge ACLK) disable iff (!ARESETN)
      local_cs ##1 local_cs |-> $stable(local_req))
      else begin
         fail_count++;
         $error("local_req changed while local_cs was high");
      end

   // the cycle after an accepted response is idle.
   a_idle_quiet: assert property (@(posedge ACLK) disable iff (!ARESETN)
      (s_axi_bvalid && s_axi_bready) || (s_axi_rvalid && s_axi_rready)
         |=> !local_cs && !s_axi_wready)
      else begin
         fail_count++;
         $error("local_cs or wready high in the idle cycle after a response");
      end

endmodule

bind axils_local_bridge uart_assertions u_assertions (.*);

// ==== rtl/axis_uart_top.sv ====
`timescale 1ns/1ps

module axis_uart_top
   import uart_bus_pkg::*;
   import uart_line_pkg::*;
(
   input  logic      ACLK,
   input  logic      ARESETN,
   input  bus_addr_t s_axi_awaddr,
   input  logic      s_axi_awvalid,
   output logic      s_axi_awready,
   input  bus_data_t s_axi_wdata,
   input  bus_strb_t s_axi_wstrb,
   input  logic      s_axi_wvalid,
   output logic      s_axi_wready,
   output logic      s_axi_bvalid,
   input  logic      s_axi_bready,
   output axi_resp_t s_axi_bresp,
   input  bus_addr_t s_axi_araddr,
   input  logic      s_axi_arvalid,
   output logic      s_axi_arready,
   output bus_data_t s_axi_rdata,
   output axi_resp_t s_axi_rresp,
   output logic      s_axi_rvalid,
   input  logic      s_axi_rready,
   output logic      uart_txd,
   input  logic      uart_rxd
);

   logic       local_cs;
   local_req_t local_req;
   logic       local_ack;
   bus_data_t  local_rdata;

   logic       tx_push;
   uart_byte_t tx_byte;
   logic       tx_full;
   logic       tx_empty;

   logic       rx_pop;
   uart_byte_t rx_byte;
   logic       rx_valid;
   logic       rx_overrun;
   logic       rx_overrun_clr;

   axils_local_bridge u_bridge (.*);

   uart_regs u_regs (.*);

   uart_tx u_tx (.*);

   uart_rx u_rx (.*);

endmodule

// ==== rtl/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx
   import uart_line_pkg::*;
(
   input  logic       ACLK,
   input  logic       ARESETN,
   input  logic       uart_rxd,
   input  logic       rx_pop,
   input  logic       rx_overrun_clr,
   output uart_byte_t rx_byte,
   output logic       rx_valid,
   output logic       rx_overrun
);

   logic [1:0] sync;
   logic       rxd_s;

   rx_state_e  state;
   baud_cnt_t  baud_cnt;
   logic [2:0] bit_idx;
   uart_byte_t shift;
   logic       bit_done;
   logic       half_done;
   logic       frame_done;

   uart_byte_t mem [FIFO_DEPTH];
   fifo_ptr_t  wr_ptr;
   fifo_ptr_t  rd_ptr;
   fifo_cnt_t  count;
   logic       full;
   logic       push_ok;
   logic       pop_ok;

   // ##############################
   // line sampler.
   // ##############################

   always_ff @(posedge ACLK or negedge ARESETN) begin
      if (!ARESETN) begin
         sync <= 2'b11;
      end else begin
         sync <= {sync[0], uart_rxd};
      end
   end

   assign rxd_s     = sync[1];
   assign bit_done  = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT - 1));
   assign half_done = (baud_cnt == baud_cnt_t'(HALF_BIT - 1));

   // a frame only counts when its stop bit is sampled high.
   assign frame_done = (state == RX_STOP) && bit_done && rxd_s;

   always_ff @(posedge ACLK or negedge ARESETN) begin
      if (!ARESETN) begin
         state    <= RX_IDLE;
         baud_cnt <= '0;
         bit_idx  <= '0;
      end else begin
         case (state)
            RX_IDLE: begin
               baud_cnt <= '0;
               if (!rxd_s) state <= RX_START;
            end
            RX_START: begin
               if (half_done) begin
                  baud_cnt <= '0;
                  bit_idx  <= '0;
                  state    <= rxd_s ? RX_IDLE : RX_DATA;
               end else begin
                  baud_cnt <= baud_cnt + 1'b1;
               end
            end
            RX_DATA: begin
               baud_cnt <= bit_done ? '0 : baud_cnt + 1'b1;
               if (bit_done) begin
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7) state <= RX_STOP;
               end
            end
            RX_STOP: begin
               baud_cnt <= bit_done ? '0 : baud_cnt + 1'b1;
               if (bit_done) state <= RX_IDLE;
            end
            default: begin
               state <= RX_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge ACLK) begin
      if (state == RX_DATA && bit_done) begin
         shift <= {rxd_s, shift[7:1]};
      end
   end

   // ##############################
   // FIFO.
   // ##############################

   assign full     = (count == fifo_cnt_t'(FIFO_DEPTH));
   assign push_ok  = frame_done && !full;
   assign pop_ok   = rx_pop && rx_valid;
   assign rx_valid = (count != '0);
   assign rx_byte  = mem[rd_ptr];

   always_ff @(posedge ACLK) begin
      if (push_ok) begin
         mem[wr_ptr] <= shift;
      end
   end

   always_ff @(posedge ACLK or negedge ARESETN) begin
      if (!ARESETN) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         rx_overrun <= 1'b0;
      end else begin
         if (push_ok) wr_ptr <= wr_ptr + 1'b1;
         if (pop_ok) rd_ptr <= rd_ptr + 1'b1;
         count <= count + fifo_cnt_t'(push_ok) - fifo_cnt_t'(pop_ok);
         // a new overrun in the same cycle as the clear is kept.
         if (frame_done && full) begin
            rx_overrun <= 1'b1;
         end else if (rx_overrun_clr) begin
            rx_overrun <= 1'b0;
         end
      end
   end

endmodule

// ==== rtl/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx
   import uart_line_pkg::*;
(
   input  logic       ACLK,
   input  logic       ARESETN,
   input  logic       tx_push,
   input  uart_byte_t tx_byte,
   output logic       tx_full,
   output logic       tx_empty,
   output logic       uart_txd
);

   uart_byte_t mem [FIFO_DEPTH];
   fifo_ptr_t  wr_ptr;
   fifo_ptr_t  rd_ptr;
   fifo_cnt_t  count;
   logic       push_ok;
   logic       pop;

   tx_state_e  state;
   baud_cnt_t  baud_cnt;
   logic [2:0] bit_idx;
   uart_byte_t shift;
   logic       bit_done;

   // ##############################
   // FIFO.
   // ##############################

   assign tx_full  = (count == fifo_cnt_t'(FIFO_DEPTH));
   assign tx_empty = (count == '0) && (state == TX_IDLE);
   assign push_ok  = tx_push && !tx_full;

   // the serializer takes the next byte when idle or right at the end of a stop bit.
   assign bit_done = (baud_cnt == baud_cnt_t'(CLKS_PER_BIT - 1));
   assign pop = (count != '0) && ((state == TX_IDLE) || (state == TX_STOP && bit_done));

   always_ff @(posedge ACLK) begin
      if (push_ok) begin
         mem[wr_ptr] <= tx_byte;
      end
   end

   always_ff @(posedge ACLK or negedge ARESETN) begin
      if (!ARESETN) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push_ok) wr_ptr <= wr_ptr + 1'b1;
         if (pop) rd_ptr <= rd_ptr + 1'b1;
         count <= count + fifo_cnt_t'(push_ok) - fifo_cnt_t'(pop);
      end
   end

   // ##############################
   // serializer.
   // ##############################

   always_ff @(posedge ACLK) begin
      if (pop) begin
         shift <= mem[rd_ptr];
      end else if (state == TX_DATA && bit_done) begin
         shift <= shift >> 1;
      end
   end

   always_ff @(posedge ACLK or negedge ARESETN) begin
      if (!ARESETN) begin
         state    <= TX_IDLE;
         baud_cnt <= '0;
         bit_idx  <= '0;
         uart_txd <= 1'b1;
      end else begin
         baud_cnt <= (state == TX_IDLE || bit_done) ? '0 : baud_cnt + 1'b1;
         case (state)
            TX_IDLE: begin
               if (pop) begin
                  state    <= TX_START;
                  uart_txd <= 1'b0;
               end
            end
            TX_START: begin
               if (bit_done) begin
                  state    <= TX_DATA;
                  bit_idx  <= '0;
                  uart_txd <= shift[0];
               end
            end
            TX_DATA: begin
               if (bit_done) begin
                  if (bit_idx == 3'd7) begin
                     state    <= TX_STOP;
                     uart_txd <= 1'b1;
                  end else begin
                     bit_idx  <= bit_idx + 1'b1;
                     uart_txd <= shift[1];
                  end
               end
            end
            TX_STOP: begin
               if (bit_done) begin
                  state    <= pop ? TX_START : TX_IDLE;
                  uart_txd <= !pop;
               end
            end
            default: begin
               state <= TX_IDLE;
            end
         endcase
      end
   end

endmodule

// ==== rtl/uart_regs.sv ====
`timescale 1ns/1ps

module uart_regs
   import uart_bus_pkg::*;
   import uart_line_pkg::*;
(
   input  logic       ACLK,
   input  logic       ARESETN,
   input  logic       local_cs,
   input  local_req_t local_req,
   output logic       local_ack,
   output bus_data_t  local_rdata,
   output logic       tx_push,
   output uart_byte_t tx_byte,
   input  logic       tx_full,
   input  logic       tx_empty,
   output logic       rx_pop,
   input  uart_byte_t rx_byte,
   input  logic       rx_valid,
   input  logic       rx_overrun,
   output logic       rx_overrun_clr
);

   logic         first;
   logic         in_window;
   logic         sel_tx;
   logic         sel_rx;
   logic         sel_st;
   uart_status_t status;
   bus_data_t    rd_word;

   // side effects fire only on the first cycle of an access.
   assign first = local_cs && !local_ack;

   assign in_window = (local_req.addr[15:4] == '0);
   assign sel_tx    = in_window && (local_req.addr[3:2] == REG_TXDATA[3:2]);
   assign sel_rx    = in_window && (local_req.addr[3:2] == REG_RXDATA[3:2]);
   assign sel_st    = in_window && (local_req.addr[3:2] == REG_STATUS[3:2]);

   assign tx_push        = first && !local_req.rnw && sel_tx && local_req.be[0];
   assign tx_byte        = local_req.wdata[7:0];
   assign rx_pop         = first && local_req.rnw && sel_rx && rx_valid;
   assign rx_overrun_clr = first && local_req.rnw && sel_st;

   assign status = '{
      tx_full:    tx_full,
      tx_empty:   tx_empty,
      rx_valid:   rx_valid,
      rx_overrun: rx_overrun
   };

   // unmapped reads and an empty RXDATA read back as zero.
   always_comb begin
      rd_word = '0;
      if (local_req.rnw) begin
         if (sel_rx && rx_valid) begin
            rd_word[7:0] = rx_byte;
         end else if (sel_st) begin
            rd_word[3:0] = status;
         end
      end
   end

   always_ff @(posedge ACLK or negedge ARESETN) begin
      if (!ARESETN) begin
         local_ack <= 1'b0;
      end else begin
         local_ack <= local_cs;
      end
   end

   always_ff @(posedge ACLK) begin
      if (first) begin
         local_rdata <= rd_word;
      end
   end

endmodule

// ==== rtl/axils_local_bridge.sv ====
`timescale 1ns/1ps

module axils_local_bridge
   import uart_bus_pkg::*;
(
   input  logic       ACLK,
   input  logic       ARESETN,
   input  bus_addr_t  s_axi_awaddr,
   input  logic       s_axi_awvalid,
   output logic       s_axi_awready,
   input  bus_data_t  s_axi_wdata,
   input  bus_strb_t  s_axi_wstrb,
   input  logic       s_axi_wvalid,
   output logic       s_axi_wready,
   output logic       s_axi_bvalid,
   input  logic       s_axi_bready,
   output axi_resp_t  s_axi_bresp,
   input  bus_addr_t  s_axi_araddr,
   input  logic       s_axi_arvalid,
   output logic       s_axi_arready,
   output bus_data_t  s_axi_rdata,
   output axi_resp_t  s_axi_rresp,
   output logic       s_axi_rvalid,
   input  logic       s_axi_rready,
   output logic       local_cs,
   output local_req_t local_req,
   input  logic       local_ack,
   input  bus_data_t  local_rdata
);

   bridge_state_e state;

   // ##############################
   // access sequencing.
   // ##############################

   always_ff @(posedge ACLK or negedge ARESETN) begin
      if (!ARESETN) begin
         state <= BR_IDLE;
      end else begin
         case (state)
            BR_IDLE: begin
               if (s_axi_awvalid) begin
                  state <= BR_WADDR;
               end else if (s_axi_arvalid) begin
                  state <= BR_READ;
               end
            end
            BR_WADDR: begin
               if (s_axi_wvalid) begin
                  state <= BR_WRITE;
               end
            end
            BR_WRITE: begin
               if (local_ack && s_axi_bready) begin
                  state <= BR_IDLE;
               end
            end
            BR_READ: begin
               if (local_ack && s_axi_rready) begin
                  state <= BR_IDLE;
               end
            end
            default: begin
               state <= BR_IDLE;
            end
         endcase
      end
   end

   // the request is captured piecewise and then held for the whole access.
   always_ff @(posedge ACLK) begin
      if (state == BR_IDLE) begin
         if (s_axi_awvalid) begin
            local_req.rnw  <= 1'b0;
            local_req.addr <= s_axi_awaddr;
         end else if (s_axi_arvalid) begin
            local_req.rnw  <= 1'b1;
            local_req.addr <= s_axi_araddr;
         end
      end
      if (state == BR_WADDR && s_axi_wvalid) begin
         local_req.wdata <= s_axi_wdata;
         local_req.be    <= s_axi_wstrb;
      end
   end

   assign local_cs = (state == BR_WRITE) || (state == BR_READ);

   // a write address wins over a read address offered in the same cycle.
   assign s_axi_awready = (state == BR_IDLE);
   assign s_axi_arready = (state == BR_IDLE) && !s_axi_awvalid;
   assign s_axi_wready  = (state == BR_WADDR);

   assign s_axi_bvalid = (state == BR_WRITE) && local_ack;
   assign s_axi_bresp  = RESP_OKAY;
   assign s_axi_rvalid = (state == BR_READ) && local_ack;
   assign s_axi_rresp  = RESP_OKAY;
   assign s_axi_rdata  = (state == BR_READ) ? local_rdata : '0;

endmodule

// ==== rtl/uart_line_pkg.sv ====
package uart_line_pkg;

   typedef logic [7:0] uart_byte_t;

   // the bit period is kept short so that simulation stays fast.
   localparam int unsigned CLKS_PER_BIT = 8;
   localparam int unsigned HALF_BIT     = CLKS_PER_BIT / 2;
   localparam int unsigned BAUD_CNT_W   = $clog2(CLKS_PER_BIT);

   localparam int unsigned FIFO_DEPTH = 16;
   localparam int unsigned FIFO_PTR_W = 4;

   typedef logic [BAUD_CNT_W-1:0] baud_cnt_t;
   typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
   typedef logic [FIFO_PTR_W:0]   fifo_cnt_t;

   // register offsets, decoded on address bits 3:2.
   localparam logic [3:0] REG_TXDATA = 4'h0;
   localparam logic [3:0] REG_RXDATA = 4'h4;
   localparam logic [3:0] REG_STATUS = 4'h8;

   typedef struct packed {
      logic tx_full;
      logic tx_empty;
      logic rx_valid;
      logic rx_overrun;
   } uart_status_t;

   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;
   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

endpackage

// ==== rtl/uart_bus_pkg.sv ====
package uart_bus_pkg;

   // byte address as seen on both the AXI4-Lite side and the local bus.
   typedef logic [15:0] bus_addr_t;
   typedef logic [31:0] bus_data_t;
   typedef logic [3:0]  bus_strb_t;
   typedef logic [1:0]  axi_resp_t;

   localparam axi_resp_t RESP_OKAY = 2'b00;

   // one local access, held by the bridge for as long as local_cs is high.
   typedef struct packed {
      logic      rnw;
      bus_addr_t addr;
      bus_strb_t be;
      bus_data_t wdata;
   } local_req_t;

   // ##############################
   // bridge FSM.
   // ##############################

   typedef enum logic [1:0] {
      BR_IDLE,
      BR_WADDR,
      BR_WRITE,
      BR_READ
   } bridge_state_e;

endpackage
